// ==== design/dcache_settings.svh ====
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// Word address, bits 18 down to 2 of the byte address
`define DCACHE_ADDR_W 17

// Direct mapped, one word per line
`define DCACHE_INDEX_W 9
`define DCACHE_TAG_W 8
`define DCACHE_DATA_W 32
`define DCACHE_LINES 512

`endif

// ==== design/dcache_pkg.sv ====
`default_nettype none

`include "dcache_settings.svh"

package dcache_pkg;

    typedef enum logic [2:0] {
        st_idle        = 3'd0,
        st_cache_read  = 3'd1,
        st_cache_write = 3'd2,
        st_mem_read    = 3'd3,
        st_mem_write   = 3'd4,
        st_done        = 3'd5
    } cache_state_e;

    typedef struct packed {
        logic [`DCACHE_TAG_W-1:0]   tag;
        logic [`DCACHE_INDEX_W-1:0] index;
    } cache_addr_fields_t;

    // Raw form goes on the memory bus, fields form drives the lookup
    typedef union packed {
        logic [`DCACHE_ADDR_W-1:0] raw;
        cache_addr_fields_t        fields;
    } cache_addr_u;

endpackage

`default_nettype wire

// ==== design/sram_port_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_settings.svh"

interface sram_port_if;

    logic                         wr_en;
    logic [`DCACHE_DATA_W/8-1:0]  wr_mask;
    logic [`DCACHE_INDEX_W-1:0]   wr_idx;
    logic [`DCACHE_DATA_W-1:0]    wr_data;
    logic                         rd_en;
    logic [`DCACHE_INDEX_W-1:0]   rd_idx;
    logic [`DCACHE_DATA_W-1:0]    rd_data;

    modport ctrl (
        output wr_en, wr_mask, wr_idx, wr_data, rd_en, rd_idx,
        input  rd_data
    );

    modport mem (
        input  wr_en, wr_mask, wr_idx, wr_data, rd_en, rd_idx,
        output rd_data
    );

endinterface

`default_nettype wire

// ==== design/dcache_sram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_settings.svh"

module dcache_sram (
    input wire         clk_i,
    sram_port_if.mem   port
);

    localparam int BYTES = `DCACHE_DATA_W / 8;

    logic [`DCACHE_DATA_W-1:0] mem_q [`DCACHE_LINES];
    logic [`DCACHE_DATA_W-1:0] rd_data_q;

    // Byte-masked write port
    always_ff @(posedge clk_i) begin
        if (port.wr_en) begin
            for (int b = 0; b < BYTES; b++) begin
                if (port.wr_mask[b]) begin
                    mem_q[port.wr_idx][8*b +: 8] <= port.wr_data[8*b +: 8];
                end
            end
        end
    end

    // Read word holds until the next read strobe
    always_ff @(posedge clk_i) begin
        if (port.rd_en) begin
            rd_data_q <= mem_q[port.rd_idx];
        end
    end

    assign port.rd_data = rd_data_q;

    // A write strobe with no bytes selected means the controller lost track
    property p_wr_mask_nonzero;
        @(posedge clk_i) port.wr_en |-> (port.wr_mask != '0);
    endproperty

    a_wr_mask_nonzero: assert property (p_wr_mask_nonzero)
        else $error("SRAM write strobe with empty byte mask");

endmodule

`default_nettype wire

// ==== design/dcache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_settings.svh"

module dcache_ctrl import dcache_pkg::*; (
    input  wire                          clk_i,
    input  wire                          rst_i,
    // Core side
    input  wire                          sel_i,
    input  wire  [`DCACHE_ADDR_W-1:0]    addr_i,
    input  wire  [`DCACHE_DATA_W-1:0]    wdata_i,
    input  wire  [`DCACHE_DATA_W/8-1:0]  mask_i,
    output logic [`DCACHE_DATA_W-1:0]    rdata_o,
    output logic                         stall_o,
    // Memory side
    output logic [`DCACHE_ADDR_W-1:0]    mem_addr_o,
    output logic                         mem_valid_o,
    output logic [`DCACHE_DATA_W-1:0]    mem_wdata_o,
    output logic [`DCACHE_DATA_W/8-1:0]  mem_wstrb_o,
    input  wire  [`DCACHE_DATA_W-1:0]    mem_rdata_i,
    input  wire                          mem_ready_i,
    // Data array
    sram_port_if.ctrl                    sram
);

    localparam int BYTES = `DCACHE_DATA_W / 8;

    cache_state_e               state_r;
    cache_state_e               state_d;

    cache_addr_u                req_addr;
    cache_addr_u                victim_addr;
    logic [`DCACHE_INDEX_W-1:0] idx;

    // Line bookkeeping
    logic [`DCACHE_TAG_W-1:0]   tag_r [`DCACHE_LINES];
    logic [`DCACHE_LINES-1:0]   valid_r;
    logic [`DCACHE_LINES-1:0]   dirty_r;

    logic                       is_write;
    logic                       is_full;
    logic                       line_hit;
    logic                       line_dirty;

    // Buffers between memory and data array
    logic                       fill_pending_r;
    logic [`DCACHE_DATA_W-1:0]  fill_r;
    logic [`DCACHE_DATA_W-1:0]  victim_r;
    logic [`DCACHE_DATA_W-1:0]  merged_word;
    logic [`DCACHE_DATA_W-1:0]  rdata_r;

    cache_addr_u                mem_addr_r;
    logic [BYTES-1:0]           mem_wstrb_r;

    assign req_addr.raw = addr_i;
    assign idx          = req_addr.fields.index;

    assign is_write   = |mask_i;
    assign is_full    = &mask_i;
    assign line_hit   = valid_r[idx] && (tag_r[idx] == req_addr.fields.tag);
    assign line_dirty = valid_r[idx] && dirty_r[idx];

    // Victim lives at the stored tag with the same index
    always_comb begin
        victim_addr.fields.tag   = tag_r[idx];
        victim_addr.fields.index = idx;
    end

    // Core bytes over the fetched word
    always_comb begin
        for (int b = 0; b < BYTES; b++) begin
            merged_word[8*b +: 8] = mask_i[b] ? wdata_i[8*b +: 8] : mem_rdata_i[8*b +: 8];
        end
    end

    always_comb begin
        state_d = state_r;
        case (state_r)
            st_idle: begin
                if (sel_i) begin
                    if (line_hit) begin
                        state_d = is_write ? st_cache_write : st_cache_read;
                    end else if (line_dirty) begin
                        // Victim word has to come out of the SRAM first
                        state_d = st_cache_read;
                    end else if (is_full) begin
                        state_d = st_cache_write;
                    end else begin
                        state_d = st_mem_read;
                    end
                end
            end
            st_cache_read: begin
                state_d = line_hit ? st_done : st_mem_write;
            end
            st_mem_write: begin
                if (mem_ready_i) begin
                    // Full word writes skip the fetch
                    state_d = is_full ? st_cache_write : st_mem_read;
                end
            end
            st_mem_read: begin
                if (mem_ready_i) begin
                    state_d = st_cache_write;
                end
            end
            st_cache_write: begin
                state_d = st_done;
            end
            st_done: begin
                state_d = st_idle;
            end
            default: begin
                state_d = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_r        <= st_idle;
            valid_r        <= '0;
            dirty_r        <= '0;
            fill_pending_r <= 1'b0;
        end else begin
            state_r <= state_d;
            if (state_r == st_mem_read && mem_ready_i) begin
                fill_pending_r <= 1'b1;
            end else if (state_r == st_done) begin
                fill_pending_r <= 1'b0;
            end
            // Reads fill clean, writes leave the line dirty
            if (state_r == st_cache_write) begin
                valid_r[idx] <= 1'b1;
                dirty_r[idx] <= is_write;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        case (state_r)
            st_idle: begin
                if (state_d == st_mem_read) begin
                    mem_addr_r  <= req_addr;
                    mem_wstrb_r <= '0;
                end
            end
            st_cache_read: begin
                rdata_r <= sram.rd_data;
                if (state_d == st_mem_write) begin
                    mem_addr_r  <= victim_addr;
                    victim_r    <= sram.rd_data;
                    mem_wstrb_r <= '1;
                end
            end
            st_mem_write: begin
                if (state_d == st_mem_read) begin
                    mem_addr_r  <= req_addr;
                    mem_wstrb_r <= '0;
                end
            end
            st_mem_read: begin
                if (mem_ready_i) begin
                    fill_r  <= merged_word;
                    rdata_r <= merged_word;
                end
            end
            st_cache_write: begin
                tag_r[idx] <= req_addr.fields.tag;
            end
            default: begin
            end
        endcase
    end

    // Data array ports
    assign sram.wr_en   = (state_r == st_cache_write);
    assign sram.wr_idx  = idx;
    assign sram.wr_data = fill_pending_r ? fill_r : wdata_i;
    assign sram.wr_mask = fill_pending_r ? {BYTES{1'b1}} : mask_i;
    assign sram.rd_en   = (state_r == st_idle) && (state_d == st_cache_read);
    assign sram.rd_idx  = idx;

    assign rdata_o = rdata_r;
    assign stall_o = sel_i && (state_r != st_done);

    assign mem_addr_o  = mem_addr_r.raw;
    assign mem_valid_o = (state_r == st_mem_read) || (state_r == st_mem_write);
    assign mem_wdata_o = victim_r;
    assign mem_wstrb_o = mem_wstrb_r;

    // Strobe register was loaded on entry and must agree with the bus phase
    property p_wstrb_phase;
        @(posedge clk_i) disable iff (rst_i)
            mem_valid_o |-> (mem_wstrb_o == {BYTES{state_r == st_mem_write}});
    endproperty

    a_wstrb_phase: assert property (p_wstrb_phase)
        else $error("mem_wstrb_o does not match the memory transaction");

    // Core must hold the address while stalled
    property p_addr_stable;
        @(posedge clk_i) disable iff (rst_i)
            (sel_i && stall_o) |=> $stable(addr_i);
    endproperty

    a_addr_stable: assert property (p_addr_stable)
        else $error("Request address changed during stall");

    property p_state_legal;
        @(posedge clk_i) disable iff (rst_i)
            state_r inside {st_idle, st_cache_read, st_cache_write,
                            st_mem_read, st_mem_write, st_done};
    endproperty

    a_state_legal: assert property (p_state_legal)
        else $error("Controller state out of range");

endmodule

`default_nettype wire

// ==== design/dcache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_settings.svh"

module dcache_top (
    input  wire                          clk_i,
    input  wire                          rst_i,
    // Core side
    input  wire                          sel_i,
    input  wire  [`DCACHE_ADDR_W-1:0]    addr_i,
    input  wire  [`DCACHE_DATA_W-1:0]    wdata_i,
    input  wire  [`DCACHE_DATA_W/8-1:0]  mask_i,
    output logic [`DCACHE_DATA_W-1:0]    rdata_o,
    output logic                         stall_o,
    // Memory side
    output logic [`DCACHE_ADDR_W-1:0]    mem_addr_o,
    output logic                         mem_valid_o,
    output logic [`DCACHE_DATA_W-1:0]    mem_wdata_o,
    output logic [`DCACHE_DATA_W/8-1:0]  mem_wstrb_o,
    input  wire  [`DCACHE_DATA_W-1:0]    mem_rdata_i,
    input  wire                          mem_ready_i
);

    sram_port_if sram_bus ();

    dcache_ctrl i_dcache_ctrl (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .sel_i       (sel_i),
        .addr_i      (addr_i),
        .wdata_i     (wdata_i),
        .mask_i      (mask_i),
        .rdata_o     (rdata_o),
        .stall_o     (stall_o),
        .mem_addr_o  (mem_addr_o),
        .mem_valid_o (mem_valid_o),
        .mem_wdata_o (mem_wdata_o),
        .mem_wstrb_o (mem_wstrb_o),
        .mem_rdata_i (mem_rdata_i),
        .mem_ready_i (mem_ready_i),
        .sram        (sram_bus.ctrl)
    );

    // Data words only, tags stay in the controller
    dcache_sram i_dcache_sram (
        .clk_i (clk_i),
        .port  (sram_bus.mem)
    );

endmodule

`default_nettype wire

// ==== bench/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS = 10
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    always begin
        #(PERIOD_NS / 2);
        clk_o = ~clk_o;
    end

endmodule

`default_nettype wire

// ==== bench/tb_main_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_settings.svh"

module tb_main_memory (
    input  wire                          clk_i,
    input  wire                          rst_i,
    input  wire  [`DCACHE_ADDR_W-1:0]    mem_addr_i,
    input  wire                          mem_valid_i,
    input  wire  [`DCACHE_DATA_W-1:0]    mem_wdata_i,
    input  wire  [`DCACHE_DATA_W/8-1:0]  mem_wstrb_i,
    output logic [`DCACHE_DATA_W-1:0]    mem_rdata_o,
    output logic                         mem_ready_o
);

    localparam int RESPONSE_DELAY_NS = 1;

    logic [`DCACHE_DATA_W-1:0]   words [2**`DCACHE_ADDR_W];
    int                          read_count;
    int                          write_count;
    int                          txn_seq;
    int                          last_rd_seq;
    int                          last_wr_seq;
    logic [`DCACHE_ADDR_W-1:0]   last_wb_addr;
    logic [`DCACHE_DATA_W-1:0]   last_wb_data;
    logic [`DCACHE_DATA_W/8-1:0] last_wb_strb;
    bit                          active;
    int                          wait_cnt;

    task automatic load_word(input logic [`DCACHE_ADDR_W-1:0] a,
                             input logic [`DCACHE_DATA_W-1:0] d);
        words[a] = d;
    endtask

    task automatic complete_transaction();
        txn_seq++;
        if (mem_wstrb_i == '0) begin
            mem_rdata_o = words[mem_addr_i];
            read_count++;
            last_rd_seq = txn_seq;
        end else begin
            for (int b = 0; b < `DCACHE_DATA_W / 8; b++) begin
                if (mem_wstrb_i[b]) begin
                    words[mem_addr_i][8*b +: 8] = mem_wdata_i[8*b +: 8];
                end
            end
            write_count++;
            last_wr_seq  = txn_seq;
            last_wb_addr = mem_addr_i;
            last_wb_data = mem_wdata_i;
            last_wb_strb = mem_wstrb_i;
        end
        mem_ready_o = 1'b1;
    endtask

    initial begin
        mem_ready_o = 1'b0;
        mem_rdata_o = '0;
        read_count  = 0;
        write_count = 0;
        txn_seq     = 0;
        last_rd_seq = 0;
        last_wr_seq = 0;
        active      = 1'b0;
        wait_cnt    = 0;
        forever begin
            @(posedge clk_i);
            #(RESPONSE_DELAY_NS);
            if (rst_i) begin
                active      = 1'b0;
                mem_ready_o = 1'b0;
            end else begin
                // Ready seen at the last edge closed that transaction
                if (mem_ready_o) begin
                    active      = 1'b0;
                    mem_ready_o = 1'b0;
                end
                if (mem_valid_i) begin
                    if (!active) begin
                        active   = 1'b1;
                        wait_cnt = $urandom_range(3, 0);
                    end
                    if (wait_cnt == 0) begin
                        complete_transaction();
                    end else begin
                        wait_cnt--;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== bench/tb_dcache.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_settings.svh"

module tb_dcache import dcache_pkg::*; ();

    localparam int          CLK_PERIOD_NS  = 10;
    localparam int          RESET_CYCLES   = 5;
    localparam int          DRIVE_DELAY_NS = 1;
    localparam int unsigned SEED           = 32'hed14167c;
    localparam int          NUM_MASKS      = 7;
    localparam int          RANDOM_REQS    = 200;
    // Cold read, hit, write and read back, masks, eviction, random mix
    localparam int NUM_REQUESTS = 1 + 1 + 2 + 2 * NUM_MASKS + 2 + RANDOM_REQS;
    localparam int WATCHDOG_NS  = NUM_REQUESTS * 20 * CLK_PERIOD_NS;

    logic                        clk;
    logic                        rst;
    logic                        sel;
    logic [`DCACHE_ADDR_W-1:0]   addr;
    logic [`DCACHE_DATA_W-1:0]   wdata;
    logic [`DCACHE_DATA_W/8-1:0] mask;
    logic [`DCACHE_DATA_W-1:0]   rdata;
    logic                        stall;
    logic [`DCACHE_ADDR_W-1:0]   mem_addr;
    logic                        mem_valid;
    logic [`DCACHE_DATA_W-1:0]   mem_wdata;
    logic [`DCACHE_DATA_W/8-1:0] mem_wstrb;
    logic [`DCACHE_DATA_W-1:0]   mem_rdata;
    logic                        mem_ready;

    // What the core should see at every word address
    logic [`DCACHE_DATA_W-1:0]   expected_mem [2**`DCACHE_ADDR_W];
    int unsigned                 seed_ret;

    tb_clock #(.PERIOD_NS(CLK_PERIOD_NS)) i_clock (.clk_o(clk));

    dcache_top i_dcache_top (
        .clk_i       (clk),
        .rst_i       (rst),
        .sel_i       (sel),
        .addr_i      (addr),
        .wdata_i     (wdata),
        .mask_i      (mask),
        .rdata_o     (rdata),
        .stall_o     (stall),
        .mem_addr_o  (mem_addr),
        .mem_valid_o (mem_valid),
        .mem_wdata_o (mem_wdata),
        .mem_wstrb_o (mem_wstrb),
        .mem_rdata_i (mem_rdata),
        .mem_ready_i (mem_ready)
    );

    tb_main_memory i_main_memory (
        .clk_i       (clk),
        .rst_i       (rst),
        .mem_addr_i  (mem_addr),
        .mem_valid_i (mem_valid),
        .mem_wdata_i (mem_wdata),
        .mem_wstrb_i (mem_wstrb),
        .mem_rdata_o (mem_rdata),
        .mem_ready_o (mem_ready)
    );

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "Run stopped at first failure");
    endtask

    task automatic check_word(input string name, input logic [`DCACHE_DATA_W-1:0] got,
                              input logic [`DCACHE_DATA_W-1:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("FAIL t=%0t %s got %h expected %h",
                                        $time, name, got, exp));
        end
    endtask

    task automatic check_mask(input string name, input logic [`DCACHE_DATA_W/8-1:0] got,
                              input logic [`DCACHE_DATA_W/8-1:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("FAIL t=%0t %s got %b expected %b",
                                        $time, name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("FAIL t=%0t %s got %b expected %b",
                                        $time, name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input cache_addr_u got,
                              input cache_addr_u exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("FAIL t=%0t %s got %h expected %h",
                                        $time, name, got.raw, exp.raw));
        end
    endtask

    task automatic check_state(input string name, input cache_state_e got,
                               input cache_state_e exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("FAIL t=%0t %s got %s expected %s",
                                        $time, name, got.name(), exp.name()));
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp) begin
            stop_with_failure($sformatf("Main memory saw %0d %s transactions, expected %0d",
                                        got, what, exp));
        end
    endtask

    function automatic cache_addr_u make_addr(input int unsigned tag, input int unsigned index);
        cache_addr_u a;
        a.fields.tag   = tag[`DCACHE_TAG_W-1:0];
        a.fields.index = index[`DCACHE_INDEX_W-1:0];
        return a;
    endfunction

    function automatic logic [`DCACHE_DATA_W-1:0] merge_bytes(
        input logic [`DCACHE_DATA_W-1:0]   old_word,
        input logic [`DCACHE_DATA_W-1:0]   new_word,
        input logic [`DCACHE_DATA_W/8-1:0] byte_mask
    );
        logic [`DCACHE_DATA_W-1:0] w;
        for (int b = 0; b < `DCACHE_DATA_W / 8; b++) begin
            w[8*b +: 8] = byte_mask[b] ? new_word[8*b +: 8] : old_word[8*b +: 8];
        end
        return w;
    endfunction

    task automatic fill_memories();
        logic [`DCACHE_DATA_W-1:0] w;
        for (int a = 0; a < 2**`DCACHE_ADDR_W; a++) begin
            w = $urandom;
            expected_mem[a[`DCACHE_ADDR_W-1:0]] = w;
            i_main_memory.load_word(a[`DCACHE_ADDR_W-1:0], w);
        end
    endtask

    // One request, held until stall_o drops, then released
    task automatic run_request(input cache_addr_u a, input logic [`DCACHE_DATA_W-1:0] w,
                               input logic [`DCACHE_DATA_W/8-1:0] m,
                               output logic [`DCACHE_DATA_W-1:0] got, output int cycles);
        @(posedge clk);
        #(DRIVE_DELAY_NS);
        sel    = 1'b1;
        addr   = a.raw;
        wdata  = w;
        mask   = m;
        cycles = 0;
        @(negedge clk);
        while (stall) begin
            cycles++;
            @(negedge clk);
        end
        got = rdata;
        if (m != '0) begin
            expected_mem[a.raw] = merge_bytes(expected_mem[a.raw], w, m);
        end
        @(posedge clk);
        #(DRIVE_DELAY_NS);
        sel = 1'b0;
    endtask

    task automatic test_after_reset();
        cache_addr_u               a;
        logic [`DCACHE_DATA_W-1:0] got;
        int                        cycles;
        int                        reads_before;
        check_flag("mem_valid_o", mem_valid, 1'b0);
        check_state("state_r", i_dcache_top.i_dcache_ctrl.state_r, st_idle);
        a = make_addr('h3c, 'h011);
        reads_before = i_main_memory.read_count;
        run_request(a, '0, '0, got, cycles);
        check_word("rdata_o", got, expected_mem[a.raw]);
        check_count("read", i_main_memory.read_count, reads_before + 1);
    endtask

    task automatic test_read_hit();
        cache_addr_u               a;
        logic [`DCACHE_DATA_W-1:0] got;
        int                        cycles;
        int                        reads_before;
        int                        writes_before;
        a = make_addr('h3c, 'h011);
        reads_before  = i_main_memory.read_count;
        writes_before = i_main_memory.write_count;
        run_request(a, '0, '0, got, cycles);
        check_word("rdata_o", got, expected_mem[a.raw]);
        check_count("read", i_main_memory.read_count, reads_before);
        check_count("write", i_main_memory.write_count, writes_before);
        if (cycles != 2) begin
            stop_with_failure($sformatf("Read hit stalled %0d cycles instead of 2", cycles));
        end
    endtask

    task automatic test_full_write();
        cache_addr_u               a;
        logic [`DCACHE_DATA_W-1:0] w;
        logic [`DCACHE_DATA_W-1:0] got;
        int                        cycles;
        int                        reads_before;
        a = make_addr('h51, 'h022);
        w = $urandom;
        reads_before = i_main_memory.read_count;
        run_request(a, w, '1, got, cycles);
        check_count("read", i_main_memory.read_count, reads_before);
        run_request(a, '0, '0, got, cycles);
        check_word("rdata_o", got, w);
        check_count("read", i_main_memory.read_count, reads_before);
    endtask

    task automatic test_partial_writes();
        logic [`DCACHE_DATA_W/8-1:0] masks [NUM_MASKS];
        cache_addr_u                 a;
        logic [`DCACHE_DATA_W-1:0]   old_word;
        logic [`DCACHE_DATA_W-1:0]   w;
        logic [`DCACHE_DATA_W-1:0]   got;
        int                          cycles;
        int                          reads_before;
        masks = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100, 4'b0101};
        for (int i = 0; i < NUM_MASKS; i++) begin
            a        = make_addr('h60 + i, 'h040 + i);
            old_word = expected_mem[a.raw];
            w        = $urandom;
            reads_before = i_main_memory.read_count;
            run_request(a, w, masks[i], got, cycles);
            check_count("read", i_main_memory.read_count, reads_before + 1);
            run_request(a, '0, '0, got, cycles);
            check_word("rdata_o", got, merge_bytes(old_word, w, masks[i]));
        end
    endtask

    task automatic test_dirty_eviction();
        cache_addr_u               a;
        cache_addr_u               b;
        cache_addr_u               wb_addr;
        logic [`DCACHE_DATA_W-1:0] w;
        logic [`DCACHE_DATA_W-1:0] got;
        int                        cycles;
        int                        reads_before;
        int                        writes_before;
        a = make_addr('h12, 'h0a5);
        b = make_addr('h34, 'h0a5);
        w = $urandom;
        run_request(a, w, '1, got, cycles);
        reads_before  = i_main_memory.read_count;
        writes_before = i_main_memory.write_count;
        run_request(b, '0, '0, got, cycles);
        check_count("write", i_main_memory.write_count, writes_before + 1);
        check_count("read", i_main_memory.read_count, reads_before + 1);
        wb_addr.raw = i_main_memory.last_wb_addr;
        check_addr("mem_addr_o", wb_addr, a);
        check_word("mem_wdata_o", i_main_memory.last_wb_data, w);
        check_mask("mem_wstrb_o", i_main_memory.last_wb_strb, '1);
        if (i_main_memory.last_wr_seq > i_main_memory.last_rd_seq) begin
            stop_with_failure("Victim writeback came after the fetch of the new word");
        end
        check_word("rdata_o", got, expected_mem[b.raw]);
    endtask

    task automatic test_random_mix();
        cache_addr_u                 a;
        logic [`DCACHE_DATA_W-1:0]   w;
        logic [`DCACHE_DATA_W-1:0]   exp_word;
        logic [`DCACHE_DATA_W-1:0]   got;
        logic [`DCACHE_DATA_W/8-1:0] m;
        int unsigned                 r;
        int                          cycles;
        for (int n = 0; n < RANDOM_REQS; n++) begin
            r = $urandom;
            // Four tags over four indices keeps evictions frequent
            a = make_addr('h80 + r[1:0], 'h100 + r[3:2]);
            w = $urandom;
            if (r[4]) begin
                m = '0;
            end else begin
                r = $urandom_range(15, 1);
                m = r[`DCACHE_DATA_W/8-1:0];
            end
            exp_word = expected_mem[a.raw];
            run_request(a, w, m, got, cycles);
            if (m == '0) begin
                check_word("rdata_o", got, exp_word);
            end
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        stop_with_failure("Watchdog expired before all requests completed");
    end

    initial begin
        seed_ret = $urandom(SEED);
        rst   = 1'b1;
        sel   = 1'b0;
        addr  = '0;
        wdata = '0;
        mask  = '0;
        fill_memories();
        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY_NS);
        rst = 1'b0;
        test_after_reset();
        test_read_hit();
        test_full_write();
        test_partial_writes();
        test_dirty_eviction();
        test_random_mix();
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+design
design/dcache_pkg.sv
design/sram_port_if.sv
design/dcache_sram.sv
design/dcache_ctrl.sv
design/dcache_top.sv
bench/tb_clock.sv
bench/tb_main_memory.sv
bench/tb_dcache.sv

// ==== Makefile ====
SOURCES := build.f $(wildcard design/*.sv design/*.svh bench/*.sv)

.PHONY: run clean

run: obj_dir/Vtb_dcache
	./obj_dir/Vtb_dcache

# Rebuilt only when a source or the file list changes
obj_dir/Vtb_dcache: $(SOURCES)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_dcache -f build.f -o Vtb_dcache

clean:
	rm -rf obj_dir
